// File: id_top.f
+incdir+hw
hw/decode_pkg.sv
hw/dec_result_if.sv
hw/reg_format_decoder.sv
hw/imm_format_decoder.sv
hw/id_stage.sv
hw/id_top.sv
tb/id_top_assert.sv
tb/tb_id_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_id_top -f id_top.f

# The simulation result is taken from its printed output
output="$(./obj_dir/Vtb_id_top 2>&1 || true)"
echo "$output"

if grep -q "Testbench passed" <<< "$output"; then
    exit 0
fi
exit 1

// File: tb/tb_id_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module tb_id_top;

    localparam logic [31:0] SEED = 32'he90f5326;
    localparam int RESET_CYCLES = 16;
    localparam int REPS = 4;
    localparam int N_OPS = 22;
    localparam int N_IDLE = 4;
    localparam int N_ILLEGAL = 20;
    localparam int N_EXCP = 12;
    localparam int N_RANDOM = 300;
    localparam int N_DRAIN = 2;
    localparam int TEST_CYCLES = N_IDLE + 18 * REPS + N_ILLEGAL + N_EXCP + N_RANDOM + N_DRAIN;
    localparam int CYCLE_LIMIT = RESET_CYCLES + TEST_CYCLES + 50;

    // Free field bits per format
    localparam logic [31:0] F17 = 32'h0000_7fff;
    localparam logic [31:0] F10 = 32'h003f_ffff;
    localparam logic [31:0] F7  = 32'h01ff_ffff;
    localparam logic [31:0] F6  = 32'h03ff_ffff;
    localparam logic [31:0] F0  = 32'h0000_0000;

    // Operand classes
    localparam logic [3:0] K_NONE = 4'd0;
    localparam logic [3:0] K_RRR  = 4'd1;
    localparam logic [3:0] K_SYS  = 4'd2;
    localparam logic [3:0] K_SIMM = 4'd3;
    localparam logic [3:0] K_ZIMM = 4'd4;
    localparam logic [3:0] K_ST   = 4'd5;
    localparam logic [3:0] K_LUI  = 4'd6;
    localparam logic [3:0] K_B    = 4'd7;
    localparam logic [3:0] K_BL   = 4'd8;

    typedef struct packed {
        logic [31:0]        base;
        logic [31:0]        free;
        logic [3:0]         kind;
        decode_pkg::aluop_e op;
    } op_entry_t;

    typedef struct packed {
        logic                         valid;
        logic [`DEC_DATA_W-1:0]       pc;
        logic [`DEC_INSTR_W-1:0]      instr;
        decode_pkg::aluop_e           aluop;
        logic [1:0]                   rd_vld;
        logic [2*`DEC_REG_ADDR_W-1:0] rd_addr;
        logic                         wr_vld;
        logic [`DEC_REG_ADDR_W-1:0]   wr_addr;
        logic                         use_imm;
        logic [`DEC_DATA_W-1:0]       imm;
        logic                         excp;
        decode_pkg::excp_num_t        excp_num;
    } disp_rec_t;

    logic                         clk_i;
    logic                         rst_n_i;
    logic                         ib_valid_i;
    logic [`DEC_DATA_W-1:0]       ib_pc_i;
    logic [`DEC_INSTR_W-1:0]      ib_instr_i;
    logic                         ib_excp_i;
    logic [`DEC_FE_EXCP_W-1:0]    ib_excp_num_i;
    logic                         has_int_i;
    logic [1:0]                   csr_plv_i;
    logic                         disp_valid_o;
    logic [`DEC_DATA_W-1:0]       disp_pc_o;
    logic [`DEC_INSTR_W-1:0]      disp_instr_o;
    decode_pkg::aluop_e           disp_aluop_o;
    logic [1:0]                   disp_reg_read_valid_o;
    logic [2*`DEC_REG_ADDR_W-1:0] disp_reg_read_addr_o;
    logic                         disp_reg_write_valid_o;
    logic [`DEC_REG_ADDR_W-1:0]   disp_reg_write_addr_o;
    logic                         disp_use_imm_o;
    logic [`DEC_DATA_W-1:0]       disp_imm_o;
    logic                         disp_excp_o;
    decode_pkg::excp_num_t        disp_excp_num_o;

    disp_rec_t   exp_q[$];
    logic [31:0] pc_next = 32'h1c00_0000;
    int unsigned driven = 0;
    int unsigned checked = 0;
    int unsigned cycles = 0;

    id_top dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ISA opcode table with fixed bits, free field bits and operand class
    function automatic op_entry_t op_entry(input int idx);
        op_entry_t e;
        case (idx)
            0:  e = {32'h0010_0000, F17, K_RRR, decode_pkg::ALU_ADD};
            1:  e = {32'h0011_0000, F17, K_RRR, decode_pkg::ALU_SUB};
            2:  e = {32'h0012_0000, F17, K_RRR, decode_pkg::ALU_SLT};
            3:  e = {32'h0012_8000, F17, K_RRR, decode_pkg::ALU_SLTU};
            4:  e = {32'h0014_0000, F17, K_RRR, decode_pkg::ALU_NOR};
            5:  e = {32'h0014_8000, F17, K_RRR, decode_pkg::ALU_AND};
            6:  e = {32'h0015_0000, F17, K_RRR, decode_pkg::ALU_OR};
            7:  e = {32'h0015_8000, F17, K_RRR, decode_pkg::ALU_XOR};
            8:  e = {32'h0017_0000, F17, K_RRR, decode_pkg::ALU_SLL};
            9:  e = {32'h002a_0000, F17, K_SYS, decode_pkg::ALU_BREAK};
            10: e = {32'h002b_0000, F17, K_SYS, decode_pkg::ALU_SYSCALL};
            11: e = {32'h0648_3800, F0, K_SYS, decode_pkg::ALU_ERTN};
            12: e = {32'h0648_8000, F17, K_SYS, decode_pkg::ALU_IDLE};
            13: e = {32'h0200_0000, F10, K_SIMM, decode_pkg::ALU_SLT};
            14: e = {32'h0280_0000, F10, K_SIMM, decode_pkg::ALU_ADD};
            15: e = {32'h0340_0000, F10, K_ZIMM, decode_pkg::ALU_AND};
            16: e = {32'h0380_0000, F10, K_ZIMM, decode_pkg::ALU_OR};
            17: e = {32'h2880_0000, F10, K_SIMM, decode_pkg::ALU_LD};
            18: e = {32'h2980_0000, F10, K_ST, decode_pkg::ALU_ST};
            19: e = {32'h1400_0000, F7, K_LUI, decode_pkg::ALU_LUI};
            20: e = {32'h5000_0000, F6, K_B, decode_pkg::ALU_B};
            21: e = {32'h5400_0000, F6, K_BL, decode_pkg::ALU_BL};
            default: e = {32'h0, F0, K_NONE, decode_pkg::ALU_NOP};
        endcase
        return e;
    endfunction

    function automatic logic [31:0] op_word(input int idx);
        op_entry_t   e;
        logic [31:0] r;
        e = op_entry(idx);
        r = $urandom;
        return e.base | (r & e.free);
    endfunction

    // Every legal opcode has bit 31 clear
    function automatic logic [31:0] illegal_word();
        logic [31:0] r;
        r = $urandom;
        r[31] = 1'b1;
        return r;
    endfunction

    function automatic disp_rec_t ref_decode(input logic v, input logic [31:0] pc,
                                             input logic [31:0] w, input logic fe_flag,
                                             input logic [3:0] code, input logic intr,
                                             input logic [1:0] plv);
        disp_rec_t   r;
        op_entry_t   e;
        op_entry_t   cand;
        logic [27:0] offs;
        r = '0;
        if (!v) return r;
        e = {32'h0, F0, K_NONE, decode_pkg::ALU_NOP};
        for (int i = 0; i < N_OPS; i++) begin
            cand = op_entry(i);
            if ((w & ~cand.free) == cand.base) e = cand;
        end
        r.valid = 1'b1;
        r.pc    = pc;
        r.instr = w;
        r.aluop = e.op;
        offs    = {w[9:0], w[25:10], 2'b00};
        case (e.kind)
            K_RRR: begin
                r.rd_vld  = 2'b11;
                r.rd_addr = {w[14:10], w[9:5]};
                r.wr_vld  = 1'b1;
                r.wr_addr = w[4:0];
            end
            K_SIMM, K_ZIMM: begin
                r.rd_vld  = 2'b01;
                r.rd_addr = {5'd0, w[9:5]};
                r.wr_vld  = 1'b1;
                r.wr_addr = w[4:0];
                r.use_imm = 1'b1;
                r.imm     = {{20{w[21] & (e.kind == K_SIMM)}}, w[21:10]};
            end
            K_ST: begin
                // Store data register rides in the high half
                r.rd_vld  = 2'b11;
                r.rd_addr = {w[4:0], w[9:5]};
                r.use_imm = 1'b1;
                r.imm     = {{20{w[21]}}, w[21:10]};
            end
            K_LUI: begin
                r.wr_vld  = 1'b1;
                r.wr_addr = w[4:0];
                r.use_imm = 1'b1;
                r.imm     = {w[24:5], 12'h000};
            end
            K_B, K_BL: begin
                r.use_imm = 1'b1;
                r.imm     = {{4{offs[27]}}, offs};
                r.wr_vld  = (e.kind == K_BL);
                r.wr_addr = (e.kind == K_BL) ? 5'd1 : 5'd0;
            end
            default: r.rd_vld = 2'b00;
        endcase
        r.excp_num.ine  = (e.kind == K_NONE);
        r.excp_num.ipe  = ((e.op == decode_pkg::ALU_ERTN) || (e.op == decode_pkg::ALU_IDLE))
                          && (plv == 2'd3);
        r.excp_num.brk  = (e.op == decode_pkg::ALU_BREAK);
        r.excp_num.sys  = (e.op == decode_pkg::ALU_SYSCALL);
        r.excp_num.fe   = fe_flag ? code : 4'h0;
        r.excp_num.intr = intr;
        r.excp = fe_flag | (|r.excp_num);
        if (r.excp) begin
            r.aluop   = decode_pkg::ALU_NOP;
            r.rd_vld  = '0;
            r.rd_addr = '0;
            r.wr_vld  = 1'b0;
            r.wr_addr = '0;
            r.use_imm = 1'b0;
            r.imm     = '0;
        end
        return r;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) fail_now($sformatf("ERR %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) fail_now($sformatf("ERR %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_aluop(input string name, input decode_pkg::aluop_e got,
                               input decode_pkg::aluop_e exp);
        if (got !== exp) fail_now($sformatf("ERR %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_excp(input string name, input decode_pkg::excp_num_t got,
                              input decode_pkg::excp_num_t exp);
        if (got !== exp) fail_now($sformatf("ERR %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic compare_record(input disp_rec_t e);
        check_bit("disp_valid_o", disp_valid_o, e.valid);
        check_word("disp_pc_o", disp_pc_o, e.pc);
        check_word("disp_instr_o", disp_instr_o, e.instr);
        check_aluop("disp_aluop_o", disp_aluop_o, e.aluop);
        check_word("disp_reg_read_valid_o", 32'(disp_reg_read_valid_o), 32'(e.rd_vld));
        check_word("disp_reg_read_addr_o", 32'(disp_reg_read_addr_o), 32'(e.rd_addr));
        check_bit("disp_reg_write_valid_o", disp_reg_write_valid_o, e.wr_vld);
        check_word("disp_reg_write_addr_o", 32'(disp_reg_write_addr_o), 32'(e.wr_addr));
        check_bit("disp_use_imm_o", disp_use_imm_o, e.use_imm);
        check_word("disp_imm_o", disp_imm_o, e.imm);
        check_bit("disp_excp_o", disp_excp_o, e.excp);
        check_excp("disp_excp_num_o", disp_excp_num_o, e.excp_num);
    endtask

    task automatic drive_slot(input logic v, input logic [31:0] w, input logic fe_flag,
                              input logic [3:0] code, input logic intr, input logic [1:0] plv);
        @(negedge clk_i);
        ib_valid_i    = v;
        ib_pc_i       = pc_next;
        ib_instr_i    = w;
        ib_excp_i     = fe_flag;
        ib_excp_num_i = code;
        has_int_i     = intr;
        csr_plv_i     = plv;
        exp_q.push_back(ref_decode(v, pc_next, w, fe_flag, code, intr, plv));
        pc_next = pc_next + 32'd4;
        driven++;
    endtask

    // Capture at the edge, compare mid-cycle while outputs are stable
    initial begin
        disp_rec_t pending;
        logic      have;
        forever begin
            @(posedge clk_i);
            have = (exp_q.size() != 0);
            if (have) pending = exp_q.pop_front();
            @(negedge clk_i);
            if (have) begin
                compare_record(pending);
                checked++;
            end
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        fail_now($sformatf("Timeout after %0d cycles with tests still running", cycles));
    end

    initial begin
        logic        v;
        logic [31:0] w;
        ib_valid_i    = 1'b0;
        ib_pc_i       = '0;
        ib_instr_i    = '0;
        ib_excp_i     = 1'b0;
        ib_excp_num_i = '0;
        has_int_i     = 1'b0;
        csr_plv_i     = 2'd0;
        rst_n_i       = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) drive_slot(1'b0, 32'h0, 1'b0, 4'h0, 1'b0, 2'd0);
        rst_n_i = 1'b1;

        // Empty slots with busy side inputs
        repeat (N_IDLE) drive_slot(1'b0, $urandom, 1'b1, 4'($urandom), 1'b1, 2'd3);

        // Register formats, then immediate formats, back to back
        for (int i = 0; i < 9; i++) begin
            repeat (REPS) drive_slot(1'b1, op_word(i), 1'b0, 4'h0, 1'b0, 2'd0);
        end
        for (int i = 13; i < N_OPS; i++) begin
            repeat (REPS) drive_slot(1'b1, op_word(i), 1'b0, 4'h0, 1'b0, 2'd0);
        end

        drive_slot(1'b1, 32'h0, 1'b0, 4'h0, 1'b0, 2'd0);
        repeat (N_ILLEGAL - 1) drive_slot(1'b1, illegal_word(), 1'b0, 4'h0, 1'b0, 2'd0);

        // Exceptions and privilege
        drive_slot(1'b1, op_word(9), 1'b0, 4'h0, 1'b0, 2'd0);
        drive_slot(1'b1, op_word(10), 1'b0, 4'h0, 1'b0, 2'd0);
        drive_slot(1'b1, op_word(11), 1'b0, 4'h0, 1'b0, 2'd3);
        drive_slot(1'b1, op_word(12), 1'b0, 4'h0, 1'b0, 2'd3);
        drive_slot(1'b1, op_word(11), 1'b0, 4'h0, 1'b0, 2'd0);
        drive_slot(1'b1, op_word(12), 1'b0, 4'h0, 1'b0, 2'd0);
        drive_slot(1'b1, op_word(0), 1'b1, 4'h3, 1'b0, 2'd0);
        drive_slot(1'b1, op_word(14), 1'b1, 4'h0, 1'b0, 2'd0);
        drive_slot(1'b1, op_word(17), 1'b1, 4'hc, 1'b0, 2'd3);
        drive_slot(1'b1, op_word(21), 1'b0, 4'h0, 1'b1, 2'd0);
        drive_slot(1'b1, op_word(1), 1'b0, 4'h0, 1'b1, 2'd3);
        drive_slot(1'b1, illegal_word(), 1'b1, 4'h5, 1'b1, 2'd1);

        for (int i = 0; i < N_RANDOM; i++) begin
            v = (($urandom % 4) != 0);
            if (($urandom % 10) < 7) w = op_word(int'($urandom % N_OPS));
            else w = illegal_word();
            drive_slot(v, w, (($urandom % 16) == 0), 4'($urandom),
                       (($urandom % 16) == 0), 2'($urandom));
        end
        repeat (N_DRAIN) drive_slot(1'b0, 32'h0, 1'b0, 4'h0, 1'b0, 2'd0);

        while (checked != driven) @(posedge clk_i);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/id_top_assert.sv
`timescale 1ns/1ps
`default_nettype none

module id_top_assert (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               ib_valid_i,
    input logic               res_reg_valid,
    input logic               res_imm_valid,
    input logic               disp_valid_o,
    input logic               disp_excp_o,
    input decode_pkg::aluop_e disp_aluop_o
);

    // Opcode sets of the two decoders are disjoint
    a_single_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(res_reg_valid && res_imm_valid))
        else $error("both format decoders matched the same word");

    // Empty slot in, empty slot out
    a_empty_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !ib_valid_i |=> !disp_valid_o)
        else $error("dispatch valid after an empty input slot");

    a_excp_is_nop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        disp_excp_o |-> (disp_aluop_o == decode_pkg::ALU_NOP))
        else $error("excepting instruction not turned into a NOP");

endmodule

bind id_stage id_top_assert u_id_top_assert (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ib_valid_i    (ib_valid_i),
    .res_reg_valid (res_reg.valid),
    .res_imm_valid (res_imm.valid),
    .disp_valid_o  (disp_valid_o),
    .disp_excp_o   (disp_excp_o),
    .disp_aluop_o  (disp_aluop_o)
);

`default_nettype wire

// File: hw/id_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module id_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         ib_valid_i,
    input  logic [`DEC_DATA_W-1:0]       ib_pc_i,
    input  logic [`DEC_INSTR_W-1:0]      ib_instr_i,
    input  logic                         ib_excp_i,
    input  logic [`DEC_FE_EXCP_W-1:0]    ib_excp_num_i,
    input  logic                         has_int_i,
    input  logic [1:0]                   csr_plv_i,
    output logic                         disp_valid_o,
    output logic [`DEC_DATA_W-1:0]       disp_pc_o,
    output logic [`DEC_INSTR_W-1:0]      disp_instr_o,
    output decode_pkg::aluop_e           disp_aluop_o,
    output logic [1:0]                   disp_reg_read_valid_o,
    output logic [2*`DEC_REG_ADDR_W-1:0] disp_reg_read_addr_o,
    output logic                         disp_reg_write_valid_o,
    output logic [`DEC_REG_ADDR_W-1:0]   disp_reg_write_addr_o,
    output logic                         disp_use_imm_o,
    output logic [`DEC_DATA_W-1:0]       disp_imm_o,
    output logic                         disp_excp_o,
    output decode_pkg::excp_num_t        disp_excp_num_o
);

    decode_pkg::instr_word_u instr_word;

    dec_result_if res_reg ();
    dec_result_if res_imm ();

    // A zero word matches no opcode, so both decoders stay silent
    assign instr_word = ib_valid_i ? ib_instr_i : '0;

    reg_format_decoder u_reg_format_decoder (
        .instr_i (instr_word),
        .res_o   (res_reg)
    );

    imm_format_decoder u_imm_format_decoder (
        .instr_i (instr_word),
        .res_o   (res_imm)
    );

    id_stage u_id_stage (
        .clk_i                  (clk_i),
        .rst_n_i                (rst_n_i),
        .ib_valid_i             (ib_valid_i),
        .ib_pc_i                (ib_pc_i),
        .ib_instr_i             (instr_word),
        .ib_excp_i              (ib_excp_i),
        .ib_excp_num_i          (ib_excp_num_i),
        .has_int_i              (has_int_i),
        .csr_plv_i              (csr_plv_i),
        .res_reg                (res_reg),
        .res_imm                (res_imm),
        .disp_valid_o           (disp_valid_o),
        .disp_pc_o              (disp_pc_o),
        .disp_instr_o           (disp_instr_o),
        .disp_aluop_o           (disp_aluop_o),
        .disp_reg_read_valid_o  (disp_reg_read_valid_o),
        .disp_reg_read_addr_o   (disp_reg_read_addr_o),
        .disp_reg_write_valid_o (disp_reg_write_valid_o),
        .disp_reg_write_addr_o  (disp_reg_write_addr_o),
        .disp_use_imm_o         (disp_use_imm_o),
        .disp_imm_o             (disp_imm_o),
        .disp_excp_o            (disp_excp_o),
        .disp_excp_num_o        (disp_excp_num_o)
    );

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module id_stage (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         ib_valid_i,
    input  logic [`DEC_DATA_W-1:0]       ib_pc_i,
    input  logic [`DEC_INSTR_W-1:0]      ib_instr_i,
    input  logic                         ib_excp_i,
    input  logic [`DEC_FE_EXCP_W-1:0]    ib_excp_num_i,
    input  logic                         has_int_i,
    input  logic [1:0]                   csr_plv_i,
    dec_result_if.sink                   res_reg,
    dec_result_if.sink                   res_imm,
    output logic                         disp_valid_o,
    output logic [`DEC_DATA_W-1:0]       disp_pc_o,
    output logic [`DEC_INSTR_W-1:0]      disp_instr_o,
    output decode_pkg::aluop_e           disp_aluop_o,
    output logic [1:0]                   disp_reg_read_valid_o,
    output logic [2*`DEC_REG_ADDR_W-1:0] disp_reg_read_addr_o,
    output logic                         disp_reg_write_valid_o,
    output logic [`DEC_REG_ADDR_W-1:0]   disp_reg_write_addr_o,
    output logic                         disp_use_imm_o,
    output logic [`DEC_DATA_W-1:0]       disp_imm_o,
    output logic                         disp_excp_o,
    output decode_pkg::excp_num_t        disp_excp_num_o
);

    logic                        dec_valid;
    decode_pkg::aluop_e          dec_aluop;
    decode_pkg::excp_num_t       excp_num;
    logic [`DEC_EXCP_NUM_W-1:0]  excp_vec;
    logic                        excp;

    // Decoders drive zero when they miss, so OR is the merge
    assign dec_valid = res_reg.valid | res_imm.valid;
    assign dec_aluop = decode_pkg::aluop_e'(res_reg.aluop | res_imm.aluop);

    assign excp_num.ipe  = ((dec_aluop == decode_pkg::ALU_ERTN) ||
                            (dec_aluop == decode_pkg::ALU_IDLE)) && (csr_plv_i == 2'b11);
    assign excp_num.ine  = ib_valid_i & ~dec_valid;
    assign excp_num.brk  = (dec_aluop == decode_pkg::ALU_BREAK);
    assign excp_num.sys  = (dec_aluop == decode_pkg::ALU_SYSCALL);
    assign excp_num.fe   = ib_excp_i ? ib_excp_num_i : '0;
    assign excp_num.intr = has_int_i;

    // A front-end fault may arrive with a zero code
    assign excp_vec = excp_num;
    assign excp     = ib_excp_i | (|excp_vec);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            disp_valid_o           <= 1'b0;
            disp_pc_o              <= '0;
            disp_instr_o           <= '0;
            disp_aluop_o           <= decode_pkg::ALU_NOP;
            disp_reg_read_valid_o  <= '0;
            disp_reg_read_addr_o   <= '0;
            disp_reg_write_valid_o <= 1'b0;
            disp_reg_write_addr_o  <= '0;
            disp_use_imm_o         <= 1'b0;
            disp_imm_o             <= '0;
            disp_excp_o            <= 1'b0;
            disp_excp_num_o        <= '0;
        end else begin
            // Empty slot clears the whole record
            disp_valid_o    <= ib_valid_i;
            disp_pc_o       <= ib_valid_i ? ib_pc_i : '0;
            disp_instr_o    <= ib_valid_i ? ib_instr_i : '0;
            disp_excp_o     <= ib_valid_i & excp;
            disp_excp_num_o <= ib_valid_i ? excp_num : '0;
            if (ib_valid_i && !excp) begin
                disp_aluop_o           <= dec_aluop;
                disp_reg_read_valid_o  <= res_reg.reg_read_valid | res_imm.reg_read_valid;
                disp_reg_read_addr_o   <= res_reg.reg_read_addr | res_imm.reg_read_addr;
                disp_reg_write_valid_o <= res_reg.reg_write_valid | res_imm.reg_write_valid;
                disp_reg_write_addr_o  <= res_reg.reg_write_addr | res_imm.reg_write_addr;
                disp_use_imm_o         <= res_reg.use_imm | res_imm.use_imm;
                disp_imm_o             <= res_reg.imm | res_imm.imm;
            end else begin
                // Exception turns the instruction into a NOP
                disp_aluop_o           <= decode_pkg::ALU_NOP;
                disp_reg_read_valid_o  <= '0;
                disp_reg_read_addr_o   <= '0;
                disp_reg_write_valid_o <= 1'b0;
                disp_reg_write_addr_o  <= '0;
                disp_use_imm_o         <= 1'b0;
                disp_imm_o             <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/imm_format_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module imm_format_decoder (
    input  decode_pkg::instr_word_u instr_i,
    dec_result_if.source            res_o
);

    // 2RI12 codes in bits 31..22
    localparam logic [9:0] OP10_SLTI   = 10'h008;
    localparam logic [9:0] OP10_ADDI_W = 10'h00a;
    localparam logic [9:0] OP10_ANDI   = 10'h00d;
    localparam logic [9:0] OP10_ORI    = 10'h00e;
    localparam logic [9:0] OP10_LD_W   = 10'h0a2;
    localparam logic [9:0] OP10_ST_W   = 10'h0a6;

    // 1RI20 code in bits 31..25 and I26 codes in bits 31..26
    localparam logic [6:0] OP7_LU12I_W = 7'h0a;
    localparam logic [5:0] OP6_B       = 6'h14;
    localparam logic [5:0] OP6_BL      = 6'h15;

    localparam logic [`DEC_REG_ADDR_W-1:0] LINK_REG = 1;

    logic [`DEC_DATA_W-1:0] imm12_sext;
    logic [`DEC_DATA_W-1:0] imm12_zext;
    logic [`DEC_DATA_W-1:0] imm20_upper;
    logic [`DEC_DATA_W-1:0] offs26_sext;
    logic [25:0]            offs26;

    // imm20 sits in bits 24..5
    assign imm20_upper = {instr_i[24:5], 12'b0};

    // Top of offs26 sits in bits 9..0 and its bottom in bits 25..10
    assign offs26      = {instr_i[9:0], instr_i[25:10]};
    assign offs26_sext = {{4{offs26[25]}}, offs26, 2'b00};

    assign imm12_sext = {{20{instr_i.imm_v.imm12[11]}}, instr_i.imm_v.imm12};
    assign imm12_zext = {20'b0, instr_i.imm_v.imm12};

    always_comb begin
        res_o.valid           = 1'b1;
        res_o.aluop           = decode_pkg::ALU_NOP;
        res_o.reg_read_valid  = 2'b01;
        res_o.reg_read_addr   = {{`DEC_REG_ADDR_W{1'b0}}, instr_i.imm_v.rj};
        res_o.reg_write_valid = 1'b1;
        res_o.reg_write_addr  = instr_i.imm_v.rd;
        res_o.use_imm         = 1'b1;
        res_o.imm             = imm12_sext;
        case (instr_i.imm_v.op10)
            OP10_SLTI:   res_o.aluop = decode_pkg::ALU_SLT;
            OP10_ADDI_W: res_o.aluop = decode_pkg::ALU_ADD;
            OP10_LD_W:   res_o.aluop = decode_pkg::ALU_LD;
            OP10_ANDI: begin
                res_o.aluop = decode_pkg::ALU_AND;
                res_o.imm   = imm12_zext;
            end
            OP10_ORI: begin
                res_o.aluop = decode_pkg::ALU_OR;
                res_o.imm   = imm12_zext;
            end
            OP10_ST_W: begin
                // Store data comes from rd
                res_o.aluop           = decode_pkg::ALU_ST;
                res_o.reg_read_valid  = 2'b11;
                res_o.reg_read_addr   = {instr_i.imm_v.rd, instr_i.imm_v.rj};
                res_o.reg_write_valid = 1'b0;
                res_o.reg_write_addr  = '0;
            end
            default: begin
                res_o.reg_read_valid = 2'b00;
                res_o.reg_read_addr  = '0;
                if (instr_i[31:25] == OP7_LU12I_W) begin
                    res_o.aluop = decode_pkg::ALU_LUI;
                    res_o.imm   = imm20_upper;
                end else if (instr_i[31:26] == OP6_BL) begin
                    res_o.aluop          = decode_pkg::ALU_BL;
                    res_o.reg_write_addr = LINK_REG;
                    res_o.imm            = offs26_sext;
                end else if (instr_i[31:26] == OP6_B) begin
                    res_o.aluop           = decode_pkg::ALU_B;
                    res_o.reg_write_valid = 1'b0;
                    res_o.reg_write_addr  = '0;
                    res_o.imm             = offs26_sext;
                end else begin
                    res_o.valid           = 1'b0;
                    res_o.reg_write_valid = 1'b0;
                    res_o.reg_write_addr  = '0;
                    res_o.use_imm         = 1'b0;
                    res_o.imm             = '0;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/reg_format_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module reg_format_decoder (
    input  decode_pkg::instr_word_u instr_i,
    dec_result_if.source            res_o
);

    // op17 codes in bits 31..15
    localparam logic [16:0] OP17_ADD_W   = 17'h00020;
    localparam logic [16:0] OP17_SUB_W   = 17'h00022;
    localparam logic [16:0] OP17_SLT     = 17'h00024;
    localparam logic [16:0] OP17_SLTU    = 17'h00025;
    localparam logic [16:0] OP17_NOR     = 17'h00028;
    localparam logic [16:0] OP17_AND     = 17'h00029;
    localparam logic [16:0] OP17_OR      = 17'h0002a;
    localparam logic [16:0] OP17_XOR     = 17'h0002b;
    localparam logic [16:0] OP17_SLL_W   = 17'h0002e;
    localparam logic [16:0] OP17_BREAK   = 17'h00054;
    localparam logic [16:0] OP17_SYSCALL = 17'h00056;
    // Idle carries a level in the low 15 bits
    localparam logic [16:0] OP17_IDLE    = 17'h00c91;

    localparam logic [`DEC_INSTR_W-1:0] ERTN_WORD = 32'h0648_3800;

    logic               hit_3r;
    decode_pkg::aluop_e op_3r;

    // Arithmetic and logic ops reading rj and rk
    always_comb begin
        hit_3r = 1'b1;
        op_3r  = decode_pkg::ALU_NOP;
        case (instr_i.reg_v.op17)
            OP17_ADD_W: op_3r = decode_pkg::ALU_ADD;
            OP17_SUB_W: op_3r = decode_pkg::ALU_SUB;
            OP17_SLT:   op_3r = decode_pkg::ALU_SLT;
            OP17_SLTU:  op_3r = decode_pkg::ALU_SLTU;
            OP17_NOR:   op_3r = decode_pkg::ALU_NOR;
            OP17_AND:   op_3r = decode_pkg::ALU_AND;
            OP17_OR:    op_3r = decode_pkg::ALU_OR;
            OP17_XOR:   op_3r = decode_pkg::ALU_XOR;
            OP17_SLL_W: op_3r = decode_pkg::ALU_SLL;
            default:    hit_3r = 1'b0;
        endcase
    end

    always_comb begin
        res_o.valid           = 1'b0;
        res_o.aluop           = decode_pkg::ALU_NOP;
        res_o.reg_read_valid  = 2'b00;
        res_o.reg_read_addr   = '0;
        res_o.reg_write_valid = 1'b0;
        res_o.reg_write_addr  = '0;
        res_o.use_imm         = 1'b0;
        res_o.imm             = '0;
        if (hit_3r) begin
            res_o.valid           = 1'b1;
            res_o.aluop           = op_3r;
            res_o.reg_read_valid  = 2'b11;
            res_o.reg_read_addr   = {instr_i.reg_v.rk, instr_i.reg_v.rj};
            res_o.reg_write_valid = 1'b1;
            res_o.reg_write_addr  = instr_i.reg_v.rd;
        end else if (instr_i.reg_v.op17 == OP17_BREAK) begin
            res_o.valid = 1'b1;
            res_o.aluop = decode_pkg::ALU_BREAK;
        end else if (instr_i.reg_v.op17 == OP17_SYSCALL) begin
            res_o.valid = 1'b1;
            res_o.aluop = decode_pkg::ALU_SYSCALL;
        end else if (instr_i == ERTN_WORD) begin
            res_o.valid = 1'b1;
            res_o.aluop = decode_pkg::ALU_ERTN;
        end else if (instr_i.reg_v.op17 == OP17_IDLE) begin
            res_o.valid = 1'b1;
            res_o.aluop = decode_pkg::ALU_IDLE;
        end
    end

endmodule

`default_nettype wire

// File: hw/dec_result_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

interface dec_result_if;

    logic                         valid;
    decode_pkg::aluop_e           aluop;
    // Bit 0 is rj, bit 1 the second operand
    logic [1:0]                   reg_read_valid;
    logic [2*`DEC_REG_ADDR_W-1:0] reg_read_addr;
    logic                         reg_write_valid;
    logic [`DEC_REG_ADDR_W-1:0]   reg_write_addr;
    logic                         use_imm;
    logic [`DEC_DATA_W-1:0]       imm;

    modport source (
        output valid, aluop, reg_read_valid, reg_read_addr,
        output reg_write_valid, reg_write_addr, use_imm, imm
    );

    modport sink (
        input valid, aluop, reg_read_valid, reg_read_addr,
        input reg_write_valid, reg_write_addr, use_imm, imm
    );

endinterface

`default_nettype wire

// File: hw/decode_pkg.sv
`default_nettype none

`include "decode_cfg.svh"

package decode_pkg;

    // ADDI and SLTI reuse ADD and SLT while ANDI and ORI reuse AND and OR
    typedef enum logic [`DEC_ALUOP_W-1:0] {
        ALU_NOP = 0,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_NOR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_BREAK,
        ALU_SYSCALL,
        ALU_ERTN,
        ALU_IDLE,
        ALU_LUI,
        ALU_LD,
        ALU_ST,
        ALU_B,
        ALU_BL
    } aluop_e;

    // 3R, 2R and privileged layout
    typedef struct packed {
        logic [16:0]                op17;
        logic [`DEC_REG_ADDR_W-1:0] rk;
        logic [`DEC_REG_ADDR_W-1:0] rj;
        logic [`DEC_REG_ADDR_W-1:0] rd;
    } reg_view_t;

    // 2RI12 layout
    typedef struct packed {
        logic [9:0]                 op10;
        logic [11:0]                imm12;
        logic [`DEC_REG_ADDR_W-1:0] rj;
        logic [`DEC_REG_ADDR_W-1:0] rd;
    } imm_view_t;

    typedef union packed {
        reg_view_t reg_v;
        imm_view_t imm_v;
    } instr_word_u;

    // From the top bit down IPE, INE, BREAK, SYSCALL, front-end code and interrupt
    typedef struct packed {
        logic                     ipe;
        logic                     ine;
        logic                     brk;
        logic                     sys;
        logic [`DEC_FE_EXCP_W-1:0] fe;
        logic                     intr;
    } excp_num_t;

endpackage

`default_nettype wire

// File: hw/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// General purpose register address
`define DEC_REG_ADDR_W 5

// Data path and immediate
`define DEC_DATA_W 32

// Instruction word
`define DEC_INSTR_W 32

// Operation code carried to dispatch
`define DEC_ALUOP_W 5

// Exception code forwarded by the front end
`define DEC_FE_EXCP_W 4

// Full exception vector of the decode stage
`define DEC_EXCP_NUM_W 9

`endif
